// ==== ooo_config.svh ====
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// data width
`define XLEN 32

// reorder buffer entries, tags 1 to 7
`define ROB_DEPTH 7

`define RS_DEPTH 4

// must hold ROB_DEPTH, tag 0 is reserved
`define TAG_W 3

`endif

// ==== design/ooo_pkg.sv ====
`include "ooo_config.svh"

package ooo_pkg;

  // one data word
  typedef logic [`XLEN-1:0] word_t;

  // architectural register number
  typedef logic [4:0] reg_id_t;

  // rob entry number where 0 means the value is present
  typedef logic [`TAG_W-1:0] tag_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT  // signed compare
  } alu_op_e;

endpackage

// ==== design/rv_decoder.sv ====
module rv_decoder (
  input  ooo_pkg::word_t   inst,
  output ooo_pkg::alu_op_e op,
  output ooo_pkg::reg_id_t rd,
  output ooo_pkg::reg_id_t rs1,
  output ooo_pkg::reg_id_t rs2,
  output ooo_pkg::word_t   imm,
  output logic             use_imm
);
  import ooo_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;

  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    op      = ALU_ADD;
    legal   = 1'b1;
    rd      = inst[11:7];
    rs1     = inst[19:15];
    rs2     = inst[24:20];
    imm     = word_t'($signed(inst[31:20]));  // sign-extended I immediate
    use_imm = 1'b0;
    case (inst[6:0])
      OPC_OP: begin
        case ({funct7, funct3})
          {7'h00, 3'b000}: op = ALU_ADD;
          {7'h20, 3'b000}: op = ALU_SUB;
          {7'h00, 3'b111}: op = ALU_AND;
          {7'h00, 3'b110}: op = ALU_OR;
          {7'h00, 3'b100}: op = ALU_XOR;
          {7'h00, 3'b010}: op = ALU_SLT;
          default:         legal = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        rs2     = '0;  // second operand is the immediate
        case (funct3)
          3'b000:  op = ALU_ADD;
          3'b111:  op = ALU_AND;
          3'b110:  op = ALU_OR;
          3'b100:  op = ALU_XOR;
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
    // anything else turns into addi x0, x0, 0 and still commits
    if (!legal) begin
      op      = ALU_ADD;
      rd      = '0;
      rs1     = '0;
      rs2     = '0;
      imm     = '0;
      use_imm = 1'b1;
    end
  end

endmodule

// ==== design/issue_unit.sv ====
module issue_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             inst_valid,
  input  ooo_pkg::word_t   inst,
  output logic             inst_ready,
  input  logic             rob_full,
  input  logic             station_full,
  input  ooo_pkg::tag_t    alloc_tag,
  output ooo_pkg::reg_id_t rs1,
  output ooo_pkg::reg_id_t rs2,
  input  ooo_pkg::word_t   rf_vj,
  input  ooo_pkg::tag_t    rf_qj,
  input  ooo_pkg::word_t   rf_vk,
  input  ooo_pkg::tag_t    rf_qk,
  output logic             rename_en,
  output ooo_pkg::reg_id_t rename_rd,
  output ooo_pkg::tag_t    rename_tag,
  output logic             alloc_en,
  output ooo_pkg::reg_id_t alloc_rd,
  input  logic             rob_j_done,
  input  ooo_pkg::word_t   rob_j_value,
  input  logic             rob_k_done,
  input  ooo_pkg::word_t   rob_k_value,
  input  logic             cdb_valid,
  input  ooo_pkg::tag_t    cdb_tag,
  input  ooo_pkg::word_t   cdb_value,
  output logic             iss_valid,
  output ooo_pkg::alu_op_e iss_op,
  output ooo_pkg::tag_t    iss_dest,
  output ooo_pkg::tag_t    iss_qj,
  output ooo_pkg::word_t   iss_vj,
  output ooo_pkg::tag_t    iss_qk,
  output ooo_pkg::word_t   iss_vk
);
  import ooo_pkg::*;

  alu_op_e op;
  reg_id_t rd;
  word_t   imm;
  logic    use_imm;
  logic    accept;
  tag_t    qj_res;
  tag_t    qk_res;
  word_t   vj_res;
  word_t   vk_res;

  rv_decoder decoder_i (
    .inst    (inst),
    .op      (op),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .imm     (imm),
    .use_imm (use_imm)
  );

  // register file first, then a finished rob entry, then this cycle's bus
  function automatic void resolve(input tag_t rf_q, input word_t rf_v, input logic rob_done,
                                  input word_t rob_v, output tag_t q, output word_t v);
    q = '0;
    v = rf_v;
    if (rf_q != '0) begin
      if (rob_done) begin
        v = rob_v;
      end else if (cdb_valid && cdb_tag == rf_q) begin
        v = cdb_value;
      end else begin
        q = rf_q;  // still in flight, station waits on the bus
      end
    end
  endfunction

  assign inst_ready = !rob_full && !station_full;
  assign accept     = inst_valid && inst_ready;

  assign rename_en  = accept;
  assign rename_rd  = rd;
  assign rename_tag = alloc_tag;
  assign alloc_en   = accept;
  assign alloc_rd   = rd;

  always_comb begin
    resolve(rf_qj, rf_vj, rob_j_done, rob_j_value, qj_res, vj_res);
    resolve(rf_qk, rf_vk, rob_k_done, rob_k_value, qk_res, vk_res);
    if (use_imm) begin
      qk_res = '0;
      vk_res = imm;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      iss_valid <= 1'b0;
      iss_dest  <= '0;
      iss_qj    <= '0;
      iss_qk    <= '0;
    end else begin
      iss_valid <= accept;  // one-cycle pulse into the station
      if (accept) begin
        iss_dest <= alloc_tag;
        iss_qj   <= qj_res;
        iss_qk   <= qk_res;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      iss_op <= op;
      iss_vj <= vj_res;
      iss_vk <= vk_res;
    end
  end

endmodule

// ==== design/reg_status_file.sv ====
module reg_status_file (
  input  logic             clk,
  input  logic             rst_n,
  input  ooo_pkg::reg_id_t rs1,
  input  ooo_pkg::reg_id_t rs2,
  input  logic             rename_en,
  input  ooo_pkg::reg_id_t rename_rd,
  input  ooo_pkg::tag_t    rename_tag,
  input  logic             commit_valid,
  input  ooo_pkg::reg_id_t commit_rd,
  input  ooo_pkg::tag_t    commit_tag,
  input  ooo_pkg::word_t   commit_value,
  output ooo_pkg::word_t   rf_vj,
  output ooo_pkg::tag_t    rf_qj,
  output ooo_pkg::word_t   rf_vk,
  output ooo_pkg::tag_t    rf_qk
);
  import ooo_pkg::*;

  word_t regs [32];
  tag_t  pend [32];  // producing rob entry, 0 when the value is architectural

  // x0 is never written so it stays 0 with tag 0
  assign rf_vj = regs[rs1];
  assign rf_qj = pend[rs1];
  assign rf_vk = regs[rs2];
  assign rf_qk = pend[rs2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
        pend[i] <= '0;
      end
    end else begin
      // only the youngest producer may clear the pending tag
      if (commit_valid && commit_rd != '0 && pend[commit_rd] == commit_tag) begin
        regs[commit_rd] <= commit_value;
        pend[commit_rd] <= '0;
      end
      if (rename_en && rename_rd != '0) begin
        pend[rename_rd] <= rename_tag;  // later write, beats a same-cycle commit
      end
    end
  end

endmodule

// ==== design/alu_station.sv ====
`include "ooo_config.svh"

module alu_station (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             iss_valid,
  input  ooo_pkg::alu_op_e iss_op,
  input  ooo_pkg::tag_t    iss_dest,
  input  ooo_pkg::tag_t    iss_qj,
  input  ooo_pkg::word_t   iss_vj,
  input  ooo_pkg::tag_t    iss_qk,
  input  ooo_pkg::word_t   iss_vk,
  output logic             station_full,
  output logic             cdb_valid,
  output ooo_pkg::tag_t    cdb_tag,
  output ooo_pkg::word_t   cdb_value
);
  import ooo_pkg::*;

  localparam int IDX_W = $clog2(`RS_DEPTH);

  logic                 valid [`RS_DEPTH];
  alu_op_e              op    [`RS_DEPTH];
  tag_t                 dest  [`RS_DEPTH];
  tag_t                 qj    [`RS_DEPTH];
  tag_t                 qk    [`RS_DEPTH];
  word_t                vj    [`RS_DEPTH];
  word_t                vk    [`RS_DEPTH];
  logic [`RS_DEPTH-1:0] older [`RS_DEPTH];  // older[i][j] when i arrived before j

  logic [`RS_DEPTH-1:0] hit_j;
  logic [`RS_DEPTH-1:0] hit_k;
  logic [`RS_DEPTH-1:0] ready;
  logic [`RS_DEPTH-1:0] oldest;
  logic [IDX_W:0]       free_cnt;
  logic [IDX_W-1:0]     ins_idx;
  logic [IDX_W-1:0]     disp_idx;
  logic                 disp_en;
  logic                 ins_hit_j;
  logic                 ins_hit_k;
  word_t                opa;
  word_t                opb;

  function automatic word_t alu(input alu_op_e f, input word_t a, input word_t b);
    case (f)
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLT: return word_t'($signed(a) < $signed(b));
      default: return a + b;
    endcase
  endfunction

  always_comb begin
    free_cnt = '0;
    ins_idx  = '0;
    disp_en  = 1'b0;
    disp_idx = '0;
    for (int i = 0; i < `RS_DEPTH; i++) begin
      hit_j[i] = valid[i] && cdb_valid && qj[i] == cdb_tag;
      hit_k[i] = valid[i] && cdb_valid && qk[i] == cdb_tag;
      ready[i] = valid[i] && (qj[i] == '0 || hit_j[i]) && (qk[i] == '0 || hit_k[i]);
    end
    for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        free_cnt = free_cnt + 1'b1;
        ins_idx  = IDX_W'(i);  // lowest free slot
      end
    end
    // oldest ready entry, no other ready entry arrived before it
    for (int i = 0; i < `RS_DEPTH; i++) begin
      oldest[i] = ready[i];
      for (int j = 0; j < `RS_DEPTH; j++) begin
        if (ready[j] && older[j][i]) oldest[i] = 1'b0;
      end
      if (oldest[i]) begin
        disp_en  = 1'b1;
        disp_idx = IDX_W'(i);
      end
    end
  end

  // one more issue can already be registered in front of us
  assign station_full = free_cnt < 2;

  assign ins_hit_j = cdb_valid && iss_qj == cdb_tag;
  assign ins_hit_k = cdb_valid && iss_qk == cdb_tag;
  assign opa       = hit_j[disp_idx] ? cdb_value : vj[disp_idx];
  assign opb       = hit_k[disp_idx] ? cdb_value : vk[disp_idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RS_DEPTH; i++) begin
        valid[i] <= 1'b0;
        qj[i]    <= '0;
        qk[i]    <= '0;
        older[i] <= '0;
      end
      cdb_valid <= 1'b0;
      cdb_tag   <= '0;
    end else begin
      for (int i = 0; i < `RS_DEPTH; i++) begin
        if (hit_j[i]) qj[i] <= '0;
        if (hit_k[i]) qk[i] <= '0;
      end
      if (disp_en) valid[disp_idx] <= 1'b0;
      if (iss_valid) begin
        valid[ins_idx] <= 1'b1;
        qj[ins_idx]    <= ins_hit_j ? tag_t'(0) : iss_qj;
        qk[ins_idx]    <= ins_hit_k ? tag_t'(0) : iss_qk;
        for (int j = 0; j < `RS_DEPTH; j++) begin
          older[j][ins_idx] <= valid[j];
        end
        older[ins_idx] <= '0;  // newest, older than nobody
      end
      cdb_valid <= disp_en;
      if (disp_en) cdb_tag <= dest[disp_idx];
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `RS_DEPTH; i++) begin
      if (hit_j[i]) vj[i] <= cdb_value;
      if (hit_k[i]) vk[i] <= cdb_value;
    end
    if (iss_valid) begin
      op[ins_idx]   <= iss_op;
      dest[ins_idx] <= iss_dest;
      vj[ins_idx]   <= ins_hit_j ? cdb_value : iss_vj;
      vk[ins_idx]   <= ins_hit_k ? cdb_value : iss_vk;
    end
    if (disp_en) cdb_value <= alu(op[disp_idx], opa, opb);
  end

endmodule

// ==== design/reorder_buffer.sv ====
`include "ooo_config.svh"

module reorder_buffer (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             alloc_en,
  input  ooo_pkg::reg_id_t alloc_rd,
  input  ooo_pkg::tag_t    qj,
  input  ooo_pkg::tag_t    qk,
  input  logic             cdb_valid,
  input  ooo_pkg::tag_t    cdb_tag,
  input  ooo_pkg::word_t   cdb_value,
  output ooo_pkg::tag_t    alloc_tag,
  output logic             rob_full,
  output logic             rob_j_done,
  output ooo_pkg::word_t   rob_j_value,
  output logic             rob_k_done,
  output ooo_pkg::word_t   rob_k_value,
  output logic             commit_valid,
  output ooo_pkg::reg_id_t commit_rd,
  output ooo_pkg::tag_t    commit_tag,
  output ooo_pkg::word_t   commit_value
);
  import ooo_pkg::*;

  localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

  logic             done    [1:`ROB_DEPTH];
  reg_id_t          rd_q    [1:`ROB_DEPTH];
  word_t            value_q [1:`ROB_DEPTH];
  tag_t             head;
  tag_t             tail;
  logic [CNT_W-1:0] count;
  logic             retire;

  function automatic tag_t next_tag(input tag_t t);
    return (t == tag_t'(`ROB_DEPTH)) ? tag_t'(1) : t + tag_t'(1);
  endfunction

  assign alloc_tag = tail;
  assign rob_full  = count == CNT_W'(`ROB_DEPTH);
  assign retire    = count != '0 && done[head];

  // done stays set after commit until the entry is reused, the register
  // file clears its tag one cycle later
  assign rob_j_done  = qj != '0 && done[qj];
  assign rob_j_value = value_q[qj];
  assign rob_k_done  = qk != '0 && done[qk];
  assign rob_k_value = value_q[qk];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i <= `ROB_DEPTH; i++) begin
        done[i] <= 1'b0;
      end
      head         <= tag_t'(1);
      tail         <= tag_t'(1);
      count        <= '0;
      commit_valid <= 1'b0;
      commit_rd    <= '0;
      commit_tag   <= '0;
    end else begin
      if (cdb_valid) done[cdb_tag] <= 1'b1;
      if (alloc_en) begin
        done[tail] <= 1'b0;
        tail       <= next_tag(tail);
      end
      if (retire) head <= next_tag(head);
      count        <= count + CNT_W'(alloc_en) - CNT_W'(retire);
      commit_valid <= retire;  // in order, one per cycle
      if (retire) begin
        commit_rd  <= rd_q[head];
        commit_tag <= head;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_en) rd_q[tail] <= alloc_rd;
    if (cdb_valid) value_q[cdb_tag] <= cdb_value;
    if (retire) commit_value <= value_q[head];
  end

endmodule

// ==== design/ooo_core.sv ====
module ooo_core (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             inst_valid,
  input  ooo_pkg::word_t   inst,
  output logic             inst_ready,
  output logic             commit_valid,
  output ooo_pkg::reg_id_t commit_rd,
  output ooo_pkg::word_t   commit_value
);
  import ooo_pkg::*;

  reg_id_t rs1;
  reg_id_t rs2;
  word_t   rf_vj;
  tag_t    rf_qj;
  word_t   rf_vk;
  tag_t    rf_qk;
  logic    rename_en;
  reg_id_t rename_rd;
  tag_t    rename_tag;
  logic    alloc_en;
  reg_id_t alloc_rd;
  tag_t    alloc_tag;
  logic    rob_full;
  logic    station_full;
  logic    rob_j_done;
  word_t   rob_j_value;
  logic    rob_k_done;
  word_t   rob_k_value;
  logic    iss_valid;
  alu_op_e iss_op;
  tag_t    iss_dest;
  tag_t    iss_qj;
  word_t   iss_vj;
  tag_t    iss_qk;
  word_t   iss_vk;
  logic    cdb_valid;   // common data bus
  tag_t    cdb_tag;
  word_t   cdb_value;
  tag_t    commit_tag;

  issue_unit issue_i (.*);

  reg_status_file regs_i (.*);

  alu_station station_i (.*);

  // rob operand lookup uses the register file's pending tags
  reorder_buffer rob_i (.qj(rf_qj), .qk(rf_qk), .*);

endmodule

// ==== verif/ooo_core_props.sv ====
module ooo_core_props (
  input logic clk,
  input logic rst_n,
  input logic inst_valid,
  input logic inst_ready,
  input logic commit_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  logic any_accept;  // set by the first handshake

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      any_accept <= 1'b0;
    end else if (inst_valid && inst_ready) begin
      any_accept <= 1'b1;
    end
  end

  quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !commit_valid)
    else $error("commit_valid high in the first cycle after reset");

  no_early_commit: assert property (@(posedge clk) disable iff (!rst_n)
    !any_accept |-> !commit_valid)
    else $error("commit_valid high before any instruction was accepted");

  ready_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(inst_ready))
    else $error("inst_ready is unknown");

  commit_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(commit_valid))
    else $error("commit_valid is unknown");

endmodule

bind ooo_core ooo_core_props props_i (.*);

// ==== verif/ooo_core_tb.sv ====
module ooo_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import ooo_pkg::*;

  logic    clk;
  logic    rst_n;
  logic    inst_valid;
  word_t   inst;
  logic    inst_ready;
  logic    commit_valid;
  reg_id_t commit_rd;
  word_t   commit_value;

  word_t   prog_q [$];
  reg_id_t rd_exp_q [$];
  word_t   val_exp_q [$];
  reg_id_t exp_rd;
  word_t   exp_val;
  int      n_lines;
  int      commit_cnt  = 0;
  int      cycle_cnt   = 0;
  int      cycle_limit = 1000;  // replaced once the stimulus is loaded
  int      seed        = 88871;

  ooo_core dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_ready   (inst_ready),
    .commit_valid (commit_valid),
    .commit_rd    (commit_rd),
    .commit_value (commit_value)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  // one program line per instruction, lines starting with # are skipped
  task automatic load_stimulus();
    int    fd;
    int    n;
    int    rd;
    string line;
    word_t w;
    word_t v;
    fd = $fopen("verif/ooo_stimulus.txt", "r");
    assert (fd != 0) else abort_run("cannot open verif/ooo_stimulus.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%h %d %h", w, rd, v);
      assert (n == 3) else abort_run("malformed line in the stimulus file");
      prog_q.push_back(w);
      rd_exp_q.push_back(reg_id_t'(rd));
      val_exp_q.push_back(v);
    end
    $fclose(fd);
    n_lines     = prog_q.size();
    cycle_limit = n_lines * 20 + 100;
  endtask

  // caller sits 2 ns after a rising edge, returns at the same offset
  task automatic send_inst(input word_t w);
    bit taken;
    inst_valid = 1'b1;
    inst       = w;
    taken      = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = inst_ready;  // value the dut saw at this edge
    end
    #2;
    inst_valid = 1'b0;
    inst       = '0;
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    assert (cycle_cnt < cycle_limit) else abort_run("timeout: commits missing");
  end

  // commits come out in program order, one expected entry each
  always @(posedge clk) begin
    if (rst_n && commit_valid) begin
      assert (rd_exp_q.size() != 0) else abort_run("commit seen after the last instruction");
      exp_rd  = rd_exp_q.pop_front();
      exp_val = val_exp_q.pop_front();
      assert (commit_rd == exp_rd && commit_value == exp_val) else begin
        $display("MISMATCH at %0t: commit %0d expected x%0d = %h, got x%0d = %h",
                 $time, commit_cnt, exp_rd, exp_val, commit_rd, commit_value);
        abort_run("commit does not match the stimulus file");
      end
      commit_cnt++;
    end
  end

  initial begin
    int gap;
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    load_stimulus();
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // nothing accepted yet so nothing may commit
    repeat (3) begin
      @(posedge clk);
      assert (!commit_valid) else abort_run("commit_valid high before any instruction");
      // empty rob and station, so the core must take an instruction
      assert (inst_ready) else begin
        $display("MISMATCH at %0t: inst_ready low with the core empty", $time);
        abort_run("inst_ready must be high after reset");
      end
    end
    #2;
    for (int i = 0; i < n_lines; i++) begin
      if (i < 3 || i > 13) begin  // lines 3 to 13 go back to back
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) begin
          @(posedge clk);
          #2;
        end
      end
      send_inst(prog_q[i]);
    end
    while (commit_cnt < n_lines) @(negedge clk);
    repeat (5) @(negedge clk);  // room for a stray extra commit
    if (commit_cnt == n_lines) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run("commit count differs from the instruction count");
    end
  end

endmodule

// ==== verif/ooo_stimulus.txt ====
# columns: instruction word (hex), expected commit rd (decimal), expected commit value (hex)
# expected values follow RV32I in program order, all registers start at 0
002081b3 3  00000000  # add  x3, x1, x2
00500093 1  00000005  # addi x1, x0, 5
ffd00113 2  fffffffd  # addi x2, x0, -3
40208233 4  00000008  # sub  x4, x1, x2
401102b3 5  fffffff8  # sub  x5, x2, x1
40100333 6  fffffffb  # sub  x6, x0, x1
001123b3 7  00000001  # slt  x7, x2, x1
0020a433 8  00000000  # slt  x8, x1, x2
0020f4b3 9  00000005  # and  x9, x1, x2
0020e533 10 fffffffd  # or   x10, x1, x2
0020c5b3 11 fffffff8  # xor  x11, x1, x2
0f017613 12 000000f0  # andi x12, x2, 0xf0
ff00e693 13 fffffff5  # ori  x13, x1, -16
fff0c713 14 fffffffa  # xori x14, x1, -1
00100793 15 00000001  # addi x15, x0, 1
00f787b3 15 00000002  # add  x15, x15, x15
00f787b3 15 00000004  # add  x15, x15, x15
00778793 15 0000000b  # addi x15, x15, 7
401787b3 15 00000006  # sub  x15, x15, x1
40108033 0  00000000  # sub  x0, x1, x1
00000000 0  00000000  # illegal word, runs as addi x0, x0, 0
00106833 16 00000005  # or   x16, x0, x1
010788b3 17 0000000b  # add  x17, x15, x16

// ==== all.f ====
+incdir+.
design/ooo_pkg.sv
design/rv_decoder.sv
design/issue_unit.sv
design/reg_status_file.sv
design/alu_station.sv
design/reorder_buffer.sv
design/ooo_core.sv
verif/ooo_core_props.sv
verif/ooo_core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module ooo_core_tb -o sim_ooo_core
./obj_dir/sim_ooo_core | tee sim.log
if grep -qF "*** TEST FAILED ***" sim.log; then
  exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
  exit 1
fi
